// ==== src/snake_key_pkg.sv ====
// keyboard scan codes for the snake game controls
`default_nettype none

package snake_key_pkg;

    typedef logic [7:0] key_code_t;

    localparam key_code_t KEY_START  = 8'h1B;
    localparam key_code_t KEY_ESC    = 8'h76;
    localparam key_code_t KEY_PAUSE  = 8'h4D;
    localparam key_code_t KEY_RESUME = 8'h2D;
    localparam key_code_t KEY_UP     = 8'h75;
    localparam key_code_t KEY_DOWN   = 8'h72;
    localparam key_code_t KEY_RIGHT  = 8'h74;
    localparam key_code_t KEY_LEFT   = 8'h6B;
    localparam key_code_t KEY_NONE   = 8'h00; // no key pending

endpackage

`default_nettype wire

// ==== src/snake_game_pkg.sv ====
// snake game coordinate, slot, state and direction types with layout constants
`default_nettype none

package snake_game_pkg;

    typedef logic [6:0] coord_t; // wraps modulo 128
    typedef logic [1:0] slot_t;
    typedef logic [1:0] lock_cnt_t;

    localparam int SEG_COUNT = 4;

    localparam coord_t WAIT_ROW  = 7'd48; // idle layout row
    localparam coord_t START_ROW = 7'd23;

    localparam lock_cnt_t TURN_LOCK_TICKS = 2'd3;

    typedef enum logic [2:0] {
        st_idle,
        st_init,
        st_blank,
        st_moving,
        st_paused
    } game_state_t;

    typedef enum logic [1:0] {
        dir_up,
        dir_down,
        dir_left,
        dir_right
    } dir_t;

endpackage

`default_nettype wire

// ==== src/snake_body_if.sv ====
// step and layout load commands from the game FSM to the segment buffer
`timescale 1ns/1ps
`default_nettype none

interface snake_body_if
    import snake_game_pkg::*;
();

    logic step;       // one move per pulse
    logic load_idle;
    logic load_start;
    dir_t dir;        // direction of the move

    modport ctrl (
        output step,
        output load_idle,
        output load_start,
        output dir
    );

    modport body (
        input step,
        input load_idle,
        input load_start,
        input dir
    );

endinterface

`default_nettype wire

// ==== src/game_tick_gen.sv ====
// game step rate divider producing a one-cycle frame_tick enable
`timescale 1ns/1ps
`default_nettype none

module game_tick_gen #(
    parameter int TICK_DIV = 20_000_000
) (
    input  wire  main_clk,
    input  wire  reset,
    output logic frame_tick
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CNT_W-1:0] TERM_CNT = CNT_W'(TICK_DIV - 1);

    logic [CNT_W-1:0] tick_cnt;

    // pulse in the cycle the counter sits at terminal count
    assign frame_tick = (tick_cnt == TERM_CNT);

    always_ff @(posedge main_clk) begin
        if (reset) begin
            tick_cnt <= '0;
        end else if (frame_tick) begin
            tick_cnt <= '0; // wrap
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/snake_ctrl_fsm.sv ====
// snake game FSM with pending key latch, direction, turn lock and pause
`timescale 1ns/1ps
`default_nettype none

module snake_ctrl_fsm
    import snake_key_pkg::*;
    import snake_game_pkg::*;
(
    input  wire                main_clk,
    input  wire                reset,
    input  wire                frame_tick,
    input  wire                key_valid,
    input  wire key_code_t     key_code,
    snake_body_if.ctrl         body,
    output logic               blank
);

    game_state_t state;
    game_state_t next_state;
    dir_t        cur_dir;
    dir_t        next_dir;
    dir_t        arrow_dir;
    lock_cnt_t   lock_cnt;
    lock_cnt_t   next_lock;
    key_code_t   pending_key;
    key_code_t   key_now;
    logic        is_arrow;

    function automatic logic is_vertical(input dir_t d);
        return (d == dir_up) || (d == dir_down);
    endfunction

    // a key in the tick cycle itself counts for that tick
    assign key_now = key_valid ? key_code : pending_key;

    always_comb begin
        is_arrow  = 1'b1;
        arrow_dir = dir_right;
        case (key_now)
            KEY_UP:    arrow_dir = dir_up;
            KEY_DOWN:  arrow_dir = dir_down;
            KEY_LEFT:  arrow_dir = dir_left;
            KEY_RIGHT: arrow_dir = dir_right;
            default:   is_arrow  = 1'b0;
        endcase
    end

    always_comb begin
        next_state = state;
        next_dir   = cur_dir;
        next_lock  = lock_cnt;

        if (state == st_moving && lock_cnt != '0) begin
            next_lock = lock_cnt - 1'b1; // lock counts down on every move
        end

        if (key_now == KEY_ESC) begin
            next_state = st_blank;
        end else if (key_now == KEY_START && state != st_init) begin
            next_state = st_init;
        end else begin
            case (state)
                st_init: begin
                    next_state = st_moving;
                    next_dir   = dir_right;
                    next_lock  = '0;
                end
                st_moving: begin
                    if (lock_cnt == '0) begin
                        if (key_now == KEY_PAUSE) begin
                            next_state = st_paused;
                        end else if (is_arrow &&
                                     (is_vertical(arrow_dir) != is_vertical(cur_dir))) begin
                            next_dir  = arrow_dir;
                            next_lock = TURN_LOCK_TICKS;
                        end
                    end
                end
                st_paused: begin
                    if (key_now == KEY_RESUME) begin
                        next_state = st_moving; // dir and lock kept
                    end
                end
                default: ;
            endcase
        end
    end

    // leaving init takes the first move to the right
    assign body.step = frame_tick &&
                       ((state == st_moving) ||
                        (state == st_init && next_state == st_moving));
    assign body.dir        = next_dir; // new direction on a turn
    assign body.load_idle  = (state == st_idle);
    assign body.load_start = (state == st_init);

    always_ff @(posedge main_clk) begin
        if (reset) begin
            state       <= st_idle;
            cur_dir     <= dir_right;
            lock_cnt    <= '0;
            pending_key <= KEY_NONE;
            blank       <= 1'b0;
        end else if (frame_tick) begin
            state       <= next_state;
            cur_dir     <= next_dir;
            lock_cnt    <= next_lock;
            pending_key <= KEY_NONE; // unused keys are dropped
            if (next_state == st_blank) begin
                blank <= 1'b1;
            end else if (next_state == st_init) begin
                blank <= 1'b0;
            end
        end else if (key_valid) begin
            pending_key <= key_code; // latest key wins
        end
    end

endmodule

`default_nettype wire

// ==== src/snake_body.sv ====
// ring buffer of snake segment positions with rotating head and tail slots
`timescale 1ns/1ps
`default_nettype none

module snake_body
    import snake_game_pkg::*;
(
    input  wire         main_clk,
    input  wire         reset,
    snake_body_if.body  body,
    output coord_t      seg_x [SEG_COUNT],
    output coord_t      seg_y [SEG_COUNT],
    output slot_t       head_slot
);

    localparam slot_t HEAD_INIT = slot_t'(SEG_COUNT - 1);
    localparam slot_t TAIL_INIT = '0;

    slot_t  tail_slot;
    coord_t head_x;
    coord_t head_y;
    coord_t step_x;
    coord_t step_y;
    coord_t layout_row;

    assign head_x = seg_x[head_slot];
    assign head_y = seg_y[head_slot];

    // next head position, coordinates wrap at 128
    always_comb begin
        step_x = head_x;
        step_y = head_y;
        case (body.dir)
            dir_up:    step_y = head_y - 1'b1;
            dir_down:  step_y = head_y + 1'b1;
            dir_left:  step_x = head_x - 1'b1;
            dir_right: step_x = head_x + 1'b1;
            default: ;
        endcase
    end

    assign layout_row = body.load_start ? START_ROW : WAIT_ROW;

    always_ff @(posedge main_clk) begin
        if (reset) begin
            for (int i = 0; i < SEG_COUNT; i++) begin
                seg_x[i] <= coord_t'(i);
                seg_y[i] <= WAIT_ROW;
            end
            head_slot <= HEAD_INIT;
            tail_slot <= TAIL_INIT;
        end else if (body.step) begin
            // old tail slot becomes the new head
            seg_x[tail_slot] <= step_x;
            seg_y[tail_slot] <= step_y;
            head_slot        <= tail_slot;
            tail_slot        <= tail_slot + 1'b1;
        end else if (body.load_idle || body.load_start) begin
            for (int i = 0; i < SEG_COUNT; i++) begin
                seg_x[i] <= coord_t'(i); // horizontal line from x=0
                seg_y[i] <= layout_row;
            end
            head_slot <= HEAD_INIT;
            tail_slot <= TAIL_INIT;
        end
    end

endmodule

`default_nettype wire

// ==== src/snake_top.sv ====
// snake game movement core top with tick divider, game FSM and segment buffer
`timescale 1ns/1ps
`default_nettype none

module snake_top
    import snake_key_pkg::*;
    import snake_game_pkg::*;
#(
    parameter int TICK_DIV = 20_000_000
) (
    input  wire            main_clk,
    input  wire            reset,
    input  wire            key_valid,
    input  wire key_code_t key_code,
    output coord_t         seg0_x,
    output coord_t         seg0_y,
    output coord_t         seg1_x,
    output coord_t         seg1_y,
    output coord_t         seg2_x,
    output coord_t         seg2_y,
    output coord_t         seg3_x,
    output coord_t         seg3_y,
    output slot_t          head_slot,
    output logic           blank,
    output logic           frame_tick
);

    coord_t seg_x [SEG_COUNT];
    coord_t seg_y [SEG_COUNT];

    snake_body_if body_bus ();

    game_tick_gen #(
        .TICK_DIV (TICK_DIV)
    ) u_tick (
        .main_clk   (main_clk),
        .reset      (reset),
        .frame_tick (frame_tick)
    );

    snake_ctrl_fsm u_ctrl (
        .main_clk   (main_clk),
        .reset      (reset),
        .frame_tick (frame_tick),
        .key_valid  (key_valid),
        .key_code   (key_code),
        .body       (body_bus),
        .blank      (blank)
    );

    snake_body u_body (
        .main_clk  (main_clk),
        .reset     (reset),
        .body      (body_bus),
        .seg_x     (seg_x),
        .seg_y     (seg_y),
        .head_slot (head_slot)
    );

    assign seg0_x = seg_x[0];
    assign seg0_y = seg_y[0];
    assign seg1_x = seg_x[1];
    assign seg1_y = seg_y[1];
    assign seg2_x = seg_x[2];
    assign seg2_y = seg_y[2];
    assign seg3_x = seg_x[3];
    assign seg3_y = seg_y[3];

endmodule

`default_nettype wire

// ==== dv/snake_checker.sv ====
// result checker for snake head position, head slot, blank and the frame_tick period
`timescale 1ns/1ps
`default_nettype none

module snake_checker
    import snake_game_pkg::*;
#(
    parameter int TICK_DIV = 16
) (
    input  wire         main_clk,
    input  wire         reset,
    input  wire         strobe,
    input  wire [15:0]  test_id,
    input  wire coord_t exp_x,
    input  wire coord_t exp_y,
    input  wire slot_t  exp_slot,
    input  wire         exp_blank,
    input  wire coord_t seg0_x,
    input  wire coord_t seg0_y,
    input  wire coord_t seg1_x,
    input  wire coord_t seg1_y,
    input  wire coord_t seg2_x,
    input  wire coord_t seg2_y,
    input  wire coord_t seg3_x,
    input  wire coord_t seg3_y,
    input  wire slot_t  head_slot,
    input  wire         blank,
    input  wire         frame_tick,
    output int          pass_count,
    output int          fail_count,
    output int          tick_errs
);

    coord_t head_x;
    coord_t head_y;
    int     tick_gap;

    // segment that head_slot points at
    always_comb begin
        case (head_slot)
            2'd0: begin
                head_x = seg0_x;
                head_y = seg0_y;
            end
            2'd1: begin
                head_x = seg1_x;
                head_y = seg1_y;
            end
            2'd2: begin
                head_x = seg2_x;
                head_y = seg2_y;
            end
            default: begin
                head_x = seg3_x;
                head_y = seg3_y;
            end
        endcase
    end

    initial begin
        pass_count = 0;
        fail_count = 0;
        tick_errs  = 0;
    end

    task automatic check_result();
        int errs;
        errs = 0;
        if (head_x !== exp_x) begin
            $display("Mismatch test %0d head_x: got 0x%02h expected 0x%02h",
                     test_id, head_x, exp_x);
            errs = errs + 1;
        end
        if (head_y !== exp_y) begin
            $display("Mismatch test %0d head_y: got 0x%02h expected 0x%02h",
                     test_id, head_y, exp_y);
            errs = errs + 1;
        end
        if (head_slot !== exp_slot) begin
            $display("Mismatch test %0d head_slot: got 0x%01h expected 0x%01h",
                     test_id, head_slot, exp_slot);
            errs = errs + 1;
        end
        if (blank !== exp_blank) begin
            $display("Mismatch test %0d blank: got 0x%01h expected 0x%01h",
                     test_id, blank, exp_blank);
            errs = errs + 1;
        end
        if (errs == 0) begin
            pass_count = pass_count + 1;
            $display("test %0d passed: head (%0d,%0d) slot %0d blank %0b",
                     test_id, head_x, head_y, head_slot, blank);
        end else begin
            fail_count = fail_count + 1;
            $display("test %0d failed with %0d mismatches", test_id, errs);
        end
    endtask

    task automatic report_counts();
        $display("tests checked %0d, passed %0d, failed %0d, tick period errors %0d",
                 pass_count + fail_count, pass_count, fail_count, tick_errs);
    endtask

    // outputs settle well before the falling edge
    always @(negedge main_clk) begin
        if (strobe) begin
            check_result();
        end
    end

    // one tick every TICK_DIV cycles, the first TICK_DIV cycles after reset
    always @(negedge main_clk) begin
        if (reset !== 1'b0) begin
            tick_gap = 0;
        end else begin
            tick_gap = tick_gap + 1;
            if (frame_tick !== (tick_gap == TICK_DIV)) begin
                $display("Mismatch frame_tick: got 0x%01h expected 0x%01h at cycle %0d",
                         frame_tick, tick_gap == TICK_DIV, tick_gap);
                tick_errs = tick_errs + 1;
            end
            if (frame_tick === 1'b1 || tick_gap >= TICK_DIV) begin
                tick_gap = 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/snake_tb.sv ====
// testbench for the snake movement core driven from a stim file
`timescale 1ns/1ps
`default_nettype none

module snake_tb
    import snake_key_pkg::*;
    import snake_game_pkg::*;
();

    localparam int TICK_DIV     = 16;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int RAND_SEED    = 87758;
    localparam int KEY_LEAD_MAX = 12; // keeps the key pulse ahead of the next tick

    logic      main_clk;
    logic      reset;
    logic      key_valid;
    key_code_t key_code;
    coord_t    seg0_x;
    coord_t    seg0_y;
    coord_t    seg1_x;
    coord_t    seg1_y;
    coord_t    seg2_x;
    coord_t    seg2_y;
    coord_t    seg3_x;
    coord_t    seg3_y;
    slot_t     head_slot;
    logic      blank;
    logic      frame_tick;

    logic        chk_strobe;
    logic [15:0] chk_id;
    coord_t      chk_x;
    coord_t      chk_y;
    slot_t       chk_slot;
    logic        chk_blank;
    int          pass_count;
    int          fail_count;
    int          tick_errs;

    int     id_q[$];
    int     key_q[$];
    int     ticks_q[$];
    int     x_q[$];
    int     y_q[$];
    int     slot_q[$];
    int     blank_q[$];
    longint timeout_ns;
    logic   stim_ready;
    logic   stim_ok;
    int     rand_dummy;

    snake_top #(
        .TICK_DIV (TICK_DIV)
    ) u_dut (
        .main_clk   (main_clk),
        .reset      (reset),
        .key_valid  (key_valid),
        .key_code   (key_code),
        .seg0_x     (seg0_x),
        .seg0_y     (seg0_y),
        .seg1_x     (seg1_x),
        .seg1_y     (seg1_y),
        .seg2_x     (seg2_x),
        .seg2_y     (seg2_y),
        .seg3_x     (seg3_x),
        .seg3_y     (seg3_y),
        .head_slot  (head_slot),
        .blank      (blank),
        .frame_tick (frame_tick)
    );

    snake_checker #(
        .TICK_DIV (TICK_DIV)
    ) u_check (
        .main_clk   (main_clk),
        .reset      (reset),
        .strobe     (chk_strobe),
        .test_id    (chk_id),
        .exp_x      (chk_x),
        .exp_y      (chk_y),
        .exp_slot   (chk_slot),
        .exp_blank  (chk_blank),
        .seg0_x     (seg0_x),
        .seg0_y     (seg0_y),
        .seg1_x     (seg1_x),
        .seg1_y     (seg1_y),
        .seg2_x     (seg2_x),
        .seg2_y     (seg2_y),
        .seg3_x     (seg3_x),
        .seg3_y     (seg3_y),
        .head_slot  (head_slot),
        .blank      (blank),
        .frame_tick (frame_tick),
        .pass_count (pass_count),
        .fail_count (fail_count),
        .tick_errs  (tick_errs)
    );

    always #(CLK_PERIOD / 2) main_clk = ~main_clk;

    task automatic load_stim(output logic ok);
        int     fd;
        string  line;
        int     n_items;
        int     f_id, f_key, f_ticks, f_x, f_y, f_slot, f_blank;
        longint total_ticks;
        total_ticks = 0;
        fd = $fopen("dv/snake_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n_items = $fgets(line, fd);
                n_items = $sscanf(line, "%d %h %d %d %d %d %d", f_id, f_key, f_ticks,
                                  f_x, f_y, f_slot, f_blank);
                if (n_items == 7) begin // comment and blank lines fall out here
                    id_q.push_back(f_id);
                    key_q.push_back(f_key);
                    ticks_q.push_back(f_ticks);
                    x_q.push_back(f_x);
                    y_q.push_back(f_y);
                    slot_q.push_back(f_slot);
                    blank_q.push_back(f_blank);
                    total_ticks = total_ticks + f_ticks;
                end
            end
            $fclose(fd);
        end
        timeout_ns = 2 * total_ticks * TICK_DIV * CLK_PERIOD + 1000;
        ok = (id_q.size() > 0);
    endtask

    // returns on the rising edge where the DUT takes the tick
    task automatic wait_tick();
        @(negedge main_clk);
        while (!frame_tick) begin
            @(negedge main_clk);
        end
        @(posedge main_clk);
    endtask

    task automatic send_key(input key_code_t code, input int lead);
        repeat (lead) @(posedge main_clk);
        @(posedge main_clk);
        key_valid <= 1'b1;
        key_code  <= code;
        @(posedge main_clk);
        key_valid <= 1'b0;
        key_code  <= KEY_NONE;
    endtask

    task automatic run_test(input int idx);
        int lead;
        lead = int'($urandom % (KEY_LEAD_MAX + 1));
        fork
            begin
                if (key_q[idx] != 0 && ticks_q[idx] > 0) begin
                    send_key(key_code_t'(key_q[idx]), lead);
                end
            end
            begin
                repeat (ticks_q[idx]) wait_tick();
            end
        join
        @(posedge main_clk); // layout loads land one cycle after the tick
        chk_strobe <= 1'b1;
        chk_id     <= 16'(id_q[idx]);
        chk_x      <= coord_t'(x_q[idx]);
        chk_y      <= coord_t'(y_q[idx]);
        chk_slot   <= slot_t'(slot_q[idx]);
        chk_blank  <= blank_q[idx][0];
        @(posedge main_clk);
        chk_strobe <= 1'b0;
    endtask

    initial begin
        rand_dummy = $urandom(RAND_SEED);
        main_clk   = 1'b0;
        reset      = 1'b1;
        key_valid  = 1'b0;
        key_code   = KEY_NONE;
        chk_strobe = 1'b0;
        chk_id     = '0;
        chk_x      = '0;
        chk_y      = '0;
        chk_slot   = '0;
        chk_blank  = 1'b0;
        stim_ready = 1'b0;
        load_stim(stim_ok);
        if (stim_ok) begin
            stim_ready = 1'b1;
            repeat (RESET_CYCLES) @(posedge main_clk);
            reset <= 1'b0;
            for (int i = 0; i < id_q.size(); i++) begin
                run_test(i);
            end
            @(posedge main_clk);
            u_check.report_counts();
        end else begin
            $display("no usable test lines found in dv/snake_stim.txt");
        end
        if (stim_ok && (pass_count + fail_count != id_q.size())) begin
            $display("checker finished %0d of %0d tests", pass_count + fail_count, id_q.size());
        end
        if (stim_ok && fail_count == 0 && tick_errs == 0 && pass_count == id_q.size()) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog sized from the tick count in the stim file
    initial begin
        wait (stim_ready);
        #(timeout_ns);
        $display("timeout: run did not finish within %0d ns", timeout_ns);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
src/snake_key_pkg.sv
src/snake_game_pkg.sv
src/snake_body_if.sv
src/game_tick_gen.sv
src/snake_ctrl_fsm.sv
src/snake_body.sv
src/snake_top.sv
dv/snake_checker.sv
dv/snake_tb.sv

// ==== dv/snake_stim.txt ====
# snake core tests, one per line, key is a hex scan code and 00 means no key
# id key ticks exp_head_x exp_head_y exp_head_slot exp_blank
# reset layout, idle holds on a tick
1 00 0 3 48 3 0
2 00 1 3 48 3 0
# start then move right
3 1B 1 3 23 3 0
4 00 1 4 23 0 0
5 00 1 5 23 1 0
6 00 1 6 23 2 0
7 00 1 7 23 3 0
8 00 2 9 23 1 0
# turn up, down and left blocked by the lock, left after the lock
9 75 1 9 22 2 0
10 72 1 9 21 3 0
11 00 1 9 20 0 0
12 6B 1 9 19 1 0
13 6B 1 8 19 2 0
14 00 3 5 19 1 0
# pause tick still steps, paused holds, arrows ignored, resume
15 4D 1 4 19 2 0
16 00 3 4 19 2 0
17 75 1 4 19 2 0
18 2D 1 4 19 2 0
19 00 2 2 19 0 0
# esc steps once then blanks, start restores the start layout
20 76 1 1 19 1 1
21 00 3 1 19 1 1
22 74 1 1 19 1 1
23 1B 1 3 23 3 0
24 00 1 4 23 0 0
# wrap through row 0 to 127
25 75 1 4 22 1 0
26 00 22 4 0 3 0
27 00 1 4 127 0 0
28 00 2 4 125 2 0
# start while moving, esc during init, reversal ignored, pause under lock
29 1B 1 3 23 3 0
30 76 1 3 23 3 1
31 1B 2 4 23 0 0
32 6B 1 5 23 1 0
33 72 1 5 24 2 0
34 4D 1 5 25 3 0
